// File: logic/axi_fifo_config.svh
//////////////////////////////
// axi_fifo config
// bus widths and buffer depths
//////////////////////////////
`ifndef AXI_FIFO_CONFIG_SVH
`define AXI_FIFO_CONFIG_SVH

`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)
`define AXI_ID_WIDTH 4

// intake and tracking depths
`define AX_FIFO_DEPTH 2
`define ID_FIFO_DEPTH 2
`define DATA_FIFO_DEPTH 2

`endif

// File: logic/axi_fifo_pkg.sv
//////////////////////////////
// axi_fifo_pkg
// shared types of the AXI to fifo bridge
//////////////////////////////
`include "axi_fifo_config.svh"

package axi_fifo_pkg;

  // one AW or AR beat
  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [7:0]                 len;
    logic [2:0]                 size;
    logic [1:0]                 burst;
  } ax_req_t;

  // one transfer out of a burst pump
  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [2:0]                 size;
    logic                       last;
  } pump_beat_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
  } wbeat_t;

  // word on the fifo output port
  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] wmask;
    logic [2:0]                 size;
    logic                       w;
  } fifo_req_t;

  // wrap is not supported, only named for checking
  typedef enum logic [1:0] {
    burst_fixed = 2'd0,
    burst_incr  = 2'd1,
    burst_wrap  = 2'd2
  } burst_e;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef enum logic [1:0] {
    state_ready,
    state_write,
    state_read
  } issue_state_e;

endpackage

// File: logic/small_fifo.sv
//////////////////////////////
// small_fifo
// circular buffer with registered ready
//////////////////////////////
`timescale 1ns/1ps

module small_fifo #(
  parameter int width_p = 8,
  parameter int els_p = 2
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;

  logic [width_p-1:0]  mem_r [els_p];
  logic [ptr_w_lp-1:0] rptr_r, wptr_r;
  logic [ptr_w_lp-1:0] rptr_n, wptr_n;
  logic                full_r;

  // pointers wrap at els_p
  assign wptr_n = (wptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
  assign rptr_n = (rptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;

  assign ready_o = ~full_r;
  assign v_o = full_r | (rptr_r != wptr_r);
  assign data_o = mem_r[rptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_r <= '0;
      wptr_r <= '0;
      full_r <= 1'b0;
    end else begin
      if (v_i) begin
        wptr_r <= wptr_n;
      end
      if (yumi_i) begin
        rptr_r <= rptr_n;
      end
      // full only after a lone enqueue catches the read pointer
      if (v_i != yumi_i) begin
        full_r <= v_i & (wptr_n == rptr_r);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  // producer and consumer must respect the handshake
  assert property (@(posedge clk_i) disable iff (reset_i) v_i |-> ready_o)
    else $error("small_fifo: enqueue while full");
  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o)
    else $error("small_fifo: dequeue while empty");

endmodule

// File: logic/burst_pump.sv
//////////////////////////////
// burst_pump
// walks an AXI burst one transfer at a time
//////////////////////////////
`timescale 1ns/1ps
`include "axi_fifo_config.svh"

module burst_pump (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     v_i,
  input  axi_fifo_pkg::ax_req_t    req_i,
  output logic                     ready_o,
  input  logic                     send_i,
  output logic                     v_o,
  output axi_fifo_pkg::pump_beat_t beat_o
);
  import axi_fifo_pkg::*;

  logic                       busy_r;
  logic                       incr_r;
  logic [7:0]                 cnt_r;
  logic [2:0]                 size_r;
  logic [`AXI_ADDR_WIDTH-1:0] addr_r;
  logic [`AXI_ADDR_WIDTH-1:0] step;
  logic [`AXI_ADDR_WIDTH-1:0] aligned;

  assign ready_o = ~busy_r;
  assign v_o = busy_r;

  // bytes per transfer, and the start address rounded down to it
  assign step = {{(`AXI_ADDR_WIDTH-1){1'b0}}, 1'b1} << size_r;
  assign aligned = addr_r & ~(step - 1'b1);

  assign beat_o.addr = addr_r;
  assign beat_o.size = size_r;
  assign beat_o.last = (cnt_r == 8'd0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
    end else if (v_i & ready_o) begin
      busy_r <= 1'b1;
    end else if (send_i & beat_o.last) begin
      busy_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i & ready_o) begin
      addr_r <= req_i.addr;
      cnt_r <= req_i.len;
      size_r <= req_i.size;
      incr_r <= (req_i.burst == burst_incr);
    end else if (send_i) begin
      cnt_r <= cnt_r - 8'd1;
      // fixed bursts keep the address
      if (incr_r) begin
        addr_r <= aligned + step;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   (v_i & ready_o) |-> (req_i.burst != burst_wrap))
    else $error("burst_pump: WRAP burst not supported");
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (v_i & ready_o) |-> ((1 << req_i.size) <= `AXI_STRB_WIDTH))
    else $error("burst_pump: size wider than the data bus");

endmodule

// File: logic/write_path.sv
//////////////////////////////
// write_path
// AW and W intake, write beats and B responses
//////////////////////////////
`timescale 1ns/1ps
`include "axi_fifo_config.svh"

module write_path (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      aw_v_i,
  input  axi_fifo_pkg::ax_req_t     aw_req_i,
  output logic                      aw_ready_o,
  input  logic                      w_v_i,
  input  axi_fifo_pkg::wbeat_t      w_beat_i,
  input  logic                      wlast_i,
  output logic                      w_ready_o,
  output logic                      beat_v_o,
  output axi_fifo_pkg::fifo_req_t   req_o,
  output logic                      last_o,
  input  logic                      send_i,
  input  logic                      ack_v_i,
  output logic                      ack_ready_o,
  output logic                      bvalid_o,
  input  logic                      bready_i,
  output logic [`AXI_ID_WIDTH-1:0]  bid_o,
  output logic [1:0]                bresp_o
);
  import axi_fifo_pkg::*;

  ax_req_t                  aw_head;
  logic                     aw_v, aw_take;
  logic                     pump_ready, pump_v;
  pump_beat_t               pump_beat;
  logic                     id_ready, id_v, id_match;
  logic [`AXI_ID_WIDTH-1:0] id_head;
  wbeat_t                   wd_head;
  logic                     wd_ready, wd_v;
  logic                     wl_ready, wl_v, wl_head, wl_yumi;
  logic                     ack_v, b_fifos_v;

  small_fifo #(.width_p($bits(ax_req_t)), .els_p(`AX_FIFO_DEPTH)) aw_fifo (
    .clk_i, .reset_i,
    .v_i(aw_v_i & aw_ready_o), .data_i(aw_req_i), .ready_o(aw_ready_o),
    .v_o(aw_v), .data_o(aw_head), .yumi_i(aw_take)
  );

  // a new burst waits until older bursts of another ID are answered
  assign id_match = ~id_v | (id_head == aw_head.id);
  assign aw_take = aw_v & pump_ready & id_ready & id_match;

  small_fifo #(.width_p(`AXI_ID_WIDTH), .els_p(`ID_FIFO_DEPTH)) id_fifo (
    .clk_i, .reset_i,
    .v_i(aw_take), .data_i(aw_head.id), .ready_o(id_ready),
    .v_o(id_v), .data_o(id_head), .yumi_i(bvalid_o & bready_i)
  );

  burst_pump aw_pump (
    .clk_i, .reset_i,
    .v_i(aw_take), .req_i(aw_head), .ready_o(pump_ready),
    .send_i, .v_o(pump_v), .beat_o(pump_beat)
  );

  // W data and its last flag enter together
  assign w_ready_o = wd_ready & wl_ready;

  small_fifo #(.width_p($bits(wbeat_t)), .els_p(`DATA_FIFO_DEPTH)) wdata_fifo (
    .clk_i, .reset_i,
    .v_i(w_v_i & w_ready_o), .data_i(w_beat_i), .ready_o(wd_ready),
    .v_o(wd_v), .data_o(wd_head), .yumi_i(send_i)
  );

  small_fifo #(.width_p(1), .els_p(`DATA_FIFO_DEPTH)) wlast_fifo (
    .clk_i, .reset_i,
    .v_i(w_v_i & w_ready_o), .data_i(wlast_i), .ready_o(wl_ready),
    .v_o(wl_v), .data_o(wl_head), .yumi_i(wl_yumi)
  );

  assign beat_v_o = pump_v & wd_v;
  assign last_o = pump_beat.last;
  assign req_o = '{addr: pump_beat.addr, data: wd_head.data, wmask: wd_head.strb,
                   size: pump_beat.size, w: 1'b1};

  // acks carry no payload, only their count matters
  small_fifo #(.width_p(1), .els_p(`DATA_FIFO_DEPTH)) ack_fifo (
    .clk_i, .reset_i,
    .v_i(ack_v_i), .data_i(1'b1), .ready_o(ack_ready_o),
    .v_o(ack_v), .data_o(), .yumi_i(wl_yumi)
  );

  // one B per burst, raised on the ack paired with wlast
  assign b_fifos_v = ack_v & wl_v & id_v;
  assign bvalid_o = b_fifos_v & wl_head;
  assign bid_o = id_head;
  assign bresp_o = resp_okay;

  // acks of inner beats are dropped
  assign wl_yumi = (bvalid_o & bready_i) | (b_fifos_v & ~wl_head);

endmodule

// File: logic/read_path.sv
//////////////////////////////
// read_path
// AR intake, read beats and R responses
//////////////////////////////
`timescale 1ns/1ps
`include "axi_fifo_config.svh"

module read_path (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       ar_v_i,
  input  axi_fifo_pkg::ax_req_t      ar_req_i,
  output logic                       ar_ready_o,
  output logic                       beat_v_o,
  output axi_fifo_pkg::fifo_req_t    req_o,
  output logic                       last_o,
  input  logic                       send_i,
  input  logic                       data_v_i,
  input  logic [`AXI_DATA_WIDTH-1:0] data_i,
  output logic                       data_ready_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic [`AXI_DATA_WIDTH-1:0] rdata_o,
  output logic [`AXI_ID_WIDTH-1:0]   rid_o,
  output logic                       rlast_o,
  output logic [1:0]                 rresp_o
);
  import axi_fifo_pkg::*;

  ax_req_t                  ar_head;
  logic                     ar_v, ar_take;
  logic                     pump_ready, pump_v, pump_send;
  pump_beat_t               pump_beat;
  logic                     id_ready, id_v, id_match;
  logic [`AXI_ID_WIDTH-1:0] id_head;
  pump_beat_t               rq_head;
  logic                     rq_ready;
  logic                     rl_ready, rl_v;
  logic                     rd_v;
  logic                     rsend;

  small_fifo #(.width_p($bits(ax_req_t)), .els_p(`AX_FIFO_DEPTH)) ar_fifo (
    .clk_i, .reset_i,
    .v_i(ar_v_i & ar_ready_o), .data_i(ar_req_i), .ready_o(ar_ready_o),
    .v_o(ar_v), .data_o(ar_head), .yumi_i(ar_take)
  );

  // same ID rule as the write side
  assign id_match = ~id_v | (id_head == ar_head.id);
  assign ar_take = ar_v & pump_ready & id_ready & id_match;

  small_fifo #(.width_p(`AXI_ID_WIDTH), .els_p(`ID_FIFO_DEPTH)) id_fifo (
    .clk_i, .reset_i,
    .v_i(ar_take), .data_i(ar_head.id), .ready_o(id_ready),
    .v_o(id_v), .data_o(id_head), .yumi_i(rsend & rlast_o)
  );

  burst_pump ar_pump (
    .clk_i, .reset_i,
    .v_i(ar_take), .req_i(ar_head), .ready_o(pump_ready),
    .send_i(pump_send), .v_o(pump_v), .beat_o(pump_beat)
  );

  // request and rlast fifos are filled in lockstep
  assign pump_send = pump_v & rq_ready & rl_ready;

  small_fifo #(.width_p($bits(pump_beat_t)), .els_p(`DATA_FIFO_DEPTH)) req_fifo (
    .clk_i, .reset_i,
    .v_i(pump_send), .data_i(pump_beat), .ready_o(rq_ready),
    .v_o(beat_v_o), .data_o(rq_head), .yumi_i(send_i)
  );

  small_fifo #(.width_p(1), .els_p(`DATA_FIFO_DEPTH)) rlast_fifo (
    .clk_i, .reset_i,
    .v_i(pump_send), .data_i(pump_beat.last), .ready_o(rl_ready),
    .v_o(rl_v), .data_o(rlast_o), .yumi_i(rsend)
  );

  assign last_o = rq_head.last;
  assign req_o = '{addr: rq_head.addr, data: '0, wmask: '0,
                   size: rq_head.size, w: 1'b0};

  small_fifo #(.width_p(`AXI_DATA_WIDTH), .els_p(`DATA_FIFO_DEPTH)) rdata_fifo (
    .clk_i, .reset_i,
    .v_i(data_v_i), .data_i(data_i), .ready_o(data_ready_o),
    .v_o(rd_v), .data_o(rdata_o), .yumi_i(rsend)
  );

  // one R beat per returned word
  assign rvalid_o = rd_v & rl_v & id_v;
  assign rsend = rvalid_o & rready_i;
  assign rid_o = id_head;
  assign rresp_o = resp_okay;

endmodule

// File: logic/issue_arbiter.sv
//////////////////////////////
// issue_arbiter
// serializes read and write beats, bursts kept whole
//////////////////////////////
`timescale 1ns/1ps

module issue_arbiter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    wr_v_i,
  input  axi_fifo_pkg::fifo_req_t wr_req_i,
  input  logic                    wr_last_i,
  input  logic                    rd_v_i,
  input  axi_fifo_pkg::fifo_req_t rd_req_i,
  input  logic                    rd_last_i,
  output logic                    v_o,
  output axi_fifo_pkg::fifo_req_t req_o,
  input  logic                    yumi_i,
  output logic                    wr_send_o,
  output logic                    rd_send_o
);
  import axi_fifo_pkg::*;

  issue_state_e state_r, state_n;
  logic         pick_rd;

  // reads win when idle
  always_comb begin
    pick_rd = 1'b0;
    v_o = 1'b0;
    case (state_r)
      state_ready: begin
        pick_rd = rd_v_i;
        v_o = rd_v_i | wr_v_i;
      end
      state_write: begin
        v_o = wr_v_i;
      end
      state_read: begin
        pick_rd = 1'b1;
        v_o = rd_v_i;
      end
      default: begin
      end
    endcase
  end

  assign req_o = pick_rd ? rd_req_i : wr_req_i;
  assign rd_send_o = yumi_i & pick_rd;
  assign wr_send_o = yumi_i & ~pick_rd;

  // an offered beat not yet taken also locks the choice,
  // so the output word holds under back-pressure
  always_comb begin
    state_n = state_r;
    case (state_r)
      state_ready: begin
        if (v_o & pick_rd & ~(rd_send_o & rd_last_i)) begin
          state_n = state_read;
        end else if (v_o & ~pick_rd & ~(wr_send_o & wr_last_i)) begin
          state_n = state_write;
        end
      end
      state_write: begin
        if (wr_send_o & wr_last_i) begin
          state_n = state_ready;
        end
      end
      state_read: begin
        if (rd_send_o & rd_last_i) begin
          state_n = state_ready;
        end
      end
      default: begin
        state_n = state_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= state_ready;
    end else begin
      state_r <= state_n;
    end
  end

  // client may only take a word that is offered
  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o)
    else $error("issue_arbiter: yumi without a valid word");
  // word must not change while the client stalls
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (v_o & ~yumi_i) |=> (v_o && $stable(req_o)))
    else $error("issue_arbiter: output word changed under back-pressure");

endmodule

// File: logic/axi_to_fifo.sv
//////////////////////////////
// axi_to_fifo
// AXI4 subordinate to in-order fifo bridge
//////////////////////////////
`timescale 1ns/1ps
`include "axi_fifo_config.svh"

module axi_to_fifo (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // AXI subordinate
  input  logic                       s_axi_awvalid_i,
  input  axi_fifo_pkg::ax_req_t      s_axi_aw_req_i,
  output logic                       s_axi_awready_o,
  input  logic                       s_axi_wvalid_i,
  input  axi_fifo_pkg::wbeat_t       s_axi_wbeat_i,
  input  logic                       s_axi_wlast_i,
  output logic                       s_axi_wready_o,
  output logic                       s_axi_bvalid_o,
  input  logic                       s_axi_bready_i,
  output logic [`AXI_ID_WIDTH-1:0]   s_axi_bid_o,
  output logic [1:0]                 s_axi_bresp_o,
  input  logic                       s_axi_arvalid_i,
  input  axi_fifo_pkg::ax_req_t      s_axi_ar_req_i,
  output logic                       s_axi_arready_o,
  output logic                       s_axi_rvalid_o,
  input  logic                       s_axi_rready_i,
  output logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata_o,
  output logic [`AXI_ID_WIDTH-1:0]   s_axi_rid_o,
  output logic                       s_axi_rlast_o,
  output logic [1:0]                 s_axi_rresp_o,
  // fifo client
  output axi_fifo_pkg::fifo_req_t    fifo_req_o,
  output logic                       v_o,
  input  logic                       yumi_i,
  input  logic [`AXI_DATA_WIDTH-1:0] data_i,
  input  logic                       v_i,
  input  logic                       w_i,
  output logic                       ready_and_o
);
  import axi_fifo_pkg::*;

  fifo_req_t wr_req, rd_req;
  logic      wr_beat_v, wr_last, wr_send, wr_ack_v, wr_ack_ready;
  logic      rd_beat_v, rd_last, rd_send, rd_data_v, rd_data_ready;

  // a response is taken only when both paths can hold it
  assign ready_and_o = wr_ack_ready & rd_data_ready;
  assign wr_ack_v = v_i & w_i & ready_and_o;
  assign rd_data_v = v_i & ~w_i & ready_and_o;

  write_path wr_path (
    .clk_i, .reset_i,
    .aw_v_i(s_axi_awvalid_i), .aw_req_i(s_axi_aw_req_i), .aw_ready_o(s_axi_awready_o),
    .w_v_i(s_axi_wvalid_i), .w_beat_i(s_axi_wbeat_i), .wlast_i(s_axi_wlast_i),
    .w_ready_o(s_axi_wready_o),
    .beat_v_o(wr_beat_v), .req_o(wr_req), .last_o(wr_last), .send_i(wr_send),
    .ack_v_i(wr_ack_v), .ack_ready_o(wr_ack_ready),
    .bvalid_o(s_axi_bvalid_o), .bready_i(s_axi_bready_i),
    .bid_o(s_axi_bid_o), .bresp_o(s_axi_bresp_o)
  );

  read_path rd_path (
    .clk_i, .reset_i,
    .ar_v_i(s_axi_arvalid_i), .ar_req_i(s_axi_ar_req_i), .ar_ready_o(s_axi_arready_o),
    .beat_v_o(rd_beat_v), .req_o(rd_req), .last_o(rd_last), .send_i(rd_send),
    .data_v_i(rd_data_v), .data_i(data_i), .data_ready_o(rd_data_ready),
    .rvalid_o(s_axi_rvalid_o), .rready_i(s_axi_rready_i), .rdata_o(s_axi_rdata_o),
    .rid_o(s_axi_rid_o), .rlast_o(s_axi_rlast_o), .rresp_o(s_axi_rresp_o)
  );

  issue_arbiter arb (
    .clk_i, .reset_i,
    .wr_v_i(wr_beat_v), .wr_req_i(wr_req), .wr_last_i(wr_last),
    .rd_v_i(rd_beat_v), .rd_req_i(rd_req), .rd_last_i(rd_last),
    .v_o(v_o), .req_o(fifo_req_o), .yumi_i(yumi_i),
    .wr_send_o(wr_send), .rd_send_o(rd_send)
  );

endmodule

// File: tests/tb_axi_to_fifo.sv
//////////////////////////////
// tb_axi_to_fifo
// directed tests with a fifo-side memory model
//////////////////////////////
`timescale 1ns/1ps
`include "axi_fifo_config.svh"

module tb_axi_to_fifo;
  import axi_fifo_pkg::*;

  // upper bound on AXI transfers over all tests
  localparam int total_beats = 50;
  localparam int watchdog_cycles = total_beats * 40 + 2000;
  localparam int mem_words = 256;
  // AXI OKAY response code
  localparam logic [1:0] okay_resp = 2'b00;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic                       last;
    logic [1:0]                 resp;
  } rbeat_t;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0] id;
    logic [1:0]               resp;
  } bresp_t;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  logic awvalid, awready, wvalid, wlast, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast;
  ax_req_t aw_req, ar_req;
  wbeat_t wbeat;
  logic [`AXI_ID_WIDTH-1:0] bid, rid;
  logic [1:0] bresp, rresp;
  logic [`AXI_DATA_WIDTH-1:0] rdata, data_in;
  fifo_req_t fifo_req;
  logic v_out, yumi, v_in, w_in, ready_and;

  logic [`AXI_DATA_WIDTH-1:0] mem [mem_words];
  logic [`AXI_DATA_WIDTH-1:0] exp_mem [mem_words];
  fifo_req_t req_log [$];
  fifo_req_t resp_q [$];
  bresp_t b_got [$], b_exp [$];
  rbeat_t r_got [$], r_exp [$];
  int wr_lens [$], rd_lens [$];
  int errors = 0;
  bit stall_en = 1'b0;

  always #10 clk_i = ~clk_i;

  axi_to_fifo DUT (
    .clk_i, .reset_i,
    .s_axi_awvalid_i(awvalid), .s_axi_aw_req_i(aw_req), .s_axi_awready_o(awready),
    .s_axi_wvalid_i(wvalid), .s_axi_wbeat_i(wbeat), .s_axi_wlast_i(wlast),
    .s_axi_wready_o(wready),
    .s_axi_bvalid_o(bvalid), .s_axi_bready_i(bready), .s_axi_bid_o(bid),
    .s_axi_bresp_o(bresp),
    .s_axi_arvalid_i(arvalid), .s_axi_ar_req_i(ar_req), .s_axi_arready_o(arready),
    .s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready), .s_axi_rdata_o(rdata),
    .s_axi_rid_o(rid), .s_axi_rlast_o(rlast), .s_axi_rresp_o(rresp),
    .fifo_req_o(fifo_req), .v_o(v_out), .yumi_i(yumi),
    .data_i(data_in), .v_i(v_in), .w_i(w_in), .ready_and_o(ready_and)
  );

  function automatic logic [31:0] fill_word(int idx);
    return {8'hc0, idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5a};
  endfunction

  function automatic int word_idx(logic [`AXI_ADDR_WIDTH-1:0] addr);
    return int'(addr[9:2]);
  endfunction

  // size 2 transfers from an aligned start
  function automatic logic [`AXI_ADDR_WIDTH-1:0] beat_addr(
      logic [`AXI_ADDR_WIDTH-1:0] addr, int k, logic [1:0] burst);
    if (burst == burst_incr) begin
      return addr + 4 * k;
    end
    return addr;
  endfunction

  function automatic void check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERR %s: got %0h expected %0h", name, got, exp);
    end
  endfunction

  function automatic void check_true(logic cond, string what);
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endfunction

  // in-order memory behind the fifo port
  function automatic void serve(fifo_req_t req);
    int idx;
    fifo_req_t rsp;
    idx = word_idx(req.addr);
    rsp = req;
    if (req.w) begin
      for (int b = 0; b < `AXI_STRB_WIDTH; b++) begin
        if (req.wmask[b]) begin
          mem[idx][8*b +: 8] = req.data[8*b +: 8];
        end
      end
    end else begin
      rsp.data = mem[idx];
    end
    resp_q.push_back(rsp);
  endfunction

  // client side and B/R monitors on the falling edge
  always @(negedge clk_i) begin
    fifo_req_t rsp;
    if (reset_i) begin
      yumi = 1'b0;
      v_in = 1'b0;
      bready = 1'b0;
      rready = 1'b0;
    end else begin
      // responses go out only while the bridge can take them
      v_in = 1'b0;
      if (resp_q.size() > 0 && ready_and && (!stall_en || $urandom_range(1) == 1)) begin
        rsp = resp_q.pop_front();
        v_in = 1'b1;
        w_in = rsp.w;
        data_in = rsp.data;
      end
      yumi = v_out && (!stall_en || $urandom_range(3) != 0);
      if (yumi) begin
        req_log.push_back(fifo_req);
        serve(fifo_req);
      end
      bready = !stall_en || $urandom_range(1) == 1;
      rready = !stall_en || $urandom_range(1) == 1;
      if (bvalid && bready) begin
        b_got.push_back('{id: bid, resp: bresp});
      end
      if (rvalid && rready) begin
        r_got.push_back('{data: rdata, id: rid, last: rlast, resp: rresp});
      end
    end
  end

  task automatic write_burst(input logic [3:0] id, input logic [31:0] addr, input int len,
                             input logic [1:0] burst);
    logic [31:0] word;
    b_exp.push_back('{id: id, resp: okay_resp});
    wr_lens.push_back(len + 1);
    @(negedge clk_i);
    aw_req = '{addr: addr, id: id, len: 8'(len), size: 3'd2, burst: burst};
    awvalid = 1'b1;
    while (!awready) @(negedge clk_i);
    @(negedge clk_i);
    awvalid = 1'b0;
    for (int k = 0; k <= len; k++) begin
      word = $urandom();
      exp_mem[word_idx(beat_addr(addr, k, burst))] = word;
      wbeat = '{data: word, strb: '1};
      wlast = (k == len);
      wvalid = 1'b1;
      while (!wready) @(negedge clk_i);
      @(negedge clk_i);
    end
    wvalid = 1'b0;
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [31:0] addr, input int len,
                            input logic [1:0] burst);
    rd_lens.push_back(len + 1);
    for (int k = 0; k <= len; k++) begin
      r_exp.push_back('{data: exp_mem[word_idx(beat_addr(addr, k, burst))], id: id,
                        last: (k == len), resp: okay_resp});
    end
    @(negedge clk_i);
    ar_req = '{addr: addr, id: id, len: 8'(len), size: 3'd2, burst: burst};
    arvalid = 1'b1;
    while (!arready) @(negedge clk_i);
    @(negedge clk_i);
    arvalid = 1'b0;
  endtask

  task automatic wait_responses();
    int cycles;
    cycles = 0;
    while ((b_got.size() < b_exp.size() || r_got.size() < r_exp.size()) && cycles < 2000) begin
      @(negedge clk_i);
      cycles++;
    end
    check_true(cycles < 2000, "responses still missing after 2000 cycles");
    // quiet window so extra responses show up
    repeat (10) @(negedge clk_i);
  endtask

  task automatic check_addrs(input logic w, input logic [31:0] addr, input int len,
                             input logic [1:0] burst);
    int k;
    k = 0;
    foreach (req_log[i]) begin
      if (req_log[i].w == w) begin
        check_value("fifo_req.addr", req_log[i].addr, beat_addr(addr, k, burst));
        check_value("fifo_req.size", req_log[i].size, 3'd2);
        k++;
      end
    end
    check_true(k == len + 1, $sformatf("saw %0d fifo requests for a %0d beat burst", k, len + 1));
  endtask

  // each burst must reach the fifo port as one unbroken run
  task automatic check_bursts_whole();
    int left;
    int extra;
    logic cur_w;
    left = 0;
    extra = 0;
    foreach (req_log[i]) begin
      if (left == 0) begin
        cur_w = req_log[i].w;
        if (cur_w && wr_lens.size() > 0) begin
          left = wr_lens.pop_front();
        end else if (!cur_w && rd_lens.size() > 0) begin
          left = rd_lens.pop_front();
        end else begin
          left = 1;
          extra++;
        end
      end else begin
        check_true(req_log[i].w == cur_w, "a burst was interleaved with the other request type");
      end
      left--;
    end
    check_true(extra == 0 && left == 0 && wr_lens.size() == 0 && rd_lens.size() == 0,
               "fifo requests do not add up to the issued bursts");
  endtask

  task automatic finish_test();
    bresp_t gb, eb;
    rbeat_t gr, er;
    check_true(b_got.size() == b_exp.size(),
               $sformatf("%0d B responses for %0d write bursts", b_got.size(), b_exp.size()));
    check_true(r_got.size() == r_exp.size(),
               $sformatf("%0d R beats for %0d read transfers", r_got.size(), r_exp.size()));
    while (b_got.size() > 0 && b_exp.size() > 0) begin
      gb = b_got.pop_front();
      eb = b_exp.pop_front();
      check_value("bid", gb.id, eb.id);
      check_value("bresp", gb.resp, eb.resp);
    end
    while (r_got.size() > 0 && r_exp.size() > 0) begin
      gr = r_got.pop_front();
      er = r_exp.pop_front();
      check_value("rdata", gr.data, er.data);
      check_value("rid", gr.id, er.id);
      check_value("rlast", gr.last, er.last);
      check_value("rresp", gr.resp, er.resp);
    end
    check_bursts_whole();
    b_got.delete();
    b_exp.delete();
    r_got.delete();
    r_exp.delete();
    req_log.delete();
  endtask

  task automatic single_write_read();
    write_burst(4'd3, 32'h40, 0, burst_incr);
    wait_responses();
    check_addrs(1'b1, 32'h40, 0, burst_incr);
    finish_test();
    read_burst(4'd5, 32'h40, 0, burst_incr);
    wait_responses();
    check_addrs(1'b0, 32'h40, 0, burst_incr);
    finish_test();
  endtask

  task automatic incr_burst();
    write_burst(4'd4, 32'h100, 3, burst_incr);
    wait_responses();
    check_addrs(1'b1, 32'h100, 3, burst_incr);
    finish_test();
    read_burst(4'd4, 32'h100, 3, burst_incr);
    wait_responses();
    check_addrs(1'b0, 32'h100, 3, burst_incr);
    finish_test();
  endtask

  task automatic fixed_burst();
    read_burst(4'd2, 32'h80, 2, burst_fixed);
    wait_responses();
    check_addrs(1'b0, 32'h80, 2, burst_fixed);
    finish_test();
  endtask

  // R order follows AR order, so ID 2 beats come last
  task automatic id_change();
    read_burst(4'd1, 32'h200, 1, burst_incr);
    read_burst(4'd1, 32'h210, 0, burst_incr);
    read_burst(4'd2, 32'h220, 2, burst_incr);
    wait_responses();
    finish_test();
  endtask

  task automatic stalled_traffic();
    int lens [3];
    stall_en = 1'b1;
    foreach (lens[i]) begin
      lens[i] = $urandom_range(3);
    end
    fork
      begin
        write_burst(4'd6, 32'h300, lens[0], burst_incr);
        write_burst(4'd6, 32'h340, lens[1], burst_incr);
        write_burst(4'd7, 32'h380, lens[2], burst_incr);
      end
      begin
        read_burst(4'd8, 32'h180, 3, burst_incr);
        read_burst(4'd9, 32'h1c0, 2, burst_incr);
      end
    join
    wait_responses();
    finish_test();
    // read every written word back
    foreach (lens[i]) begin
      read_burst(4'd10, 32'h300 + 32'h40 * i, lens[i], burst_incr);
    end
    wait_responses();
    finish_test();
    stall_en = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h80b8));
    awvalid = 1'b0;
    aw_req = '0;
    wvalid = 1'b0;
    wbeat = '0;
    wlast = 1'b0;
    bready = 1'b0;
    arvalid = 1'b0;
    ar_req = '0;
    rready = 1'b0;
    yumi = 1'b0;
    v_in = 1'b0;
    w_in = 1'b0;
    data_in = '0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = fill_word(i);
      exp_mem[i] = fill_word(i);
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    check_true(!v_out && !bvalid && !rvalid, "outputs not idle during reset");
    reset_i = 1'b0;
    single_write_read();
    incr_burst();
    fixed_burst();
    id_change();
    stalled_traffic();
    repeat (5) @(negedge clk_i);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("run stopped by the watchdog after %0d cycles", watchdog_cycles);
    $display("errors: %0d", errors);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: list.f
+incdir+logic
logic/axi_fifo_pkg.sv
logic/small_fifo.sv
logic/burst_pump.sv
logic/write_path.sv
logic/read_path.sv
logic/issue_arbiter.sv
logic/axi_to_fifo.sv
tests/tb_axi_to_fifo.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_to_fifo
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f list.f
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	! grep -q "Checks failed" $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
